//--- src/exec_pkg.sv
`default_nettype none

package exec_pkg;

    // Architectural register file size
    localparam int REG_COUNT = 32;

    // Shift amount bits taken from operand b
    localparam int SHAMT_W = 5;

    typedef logic [4:0] reg_idx_t;

    // Decoded operation, as delivered by the decode stage
    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        // Low half of the product
        OP_MUL,
        OP_DIVU,
        OP_REMU
    } op_e;

endpackage

`default_nettype wire

//--- src/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file import exec_pkg::*; #(
    parameter int XLEN = 32
) (
    input  wire logic            clk,
    input  wire logic            resetn,

    input  wire reg_idx_t        i_ra_sel,
    output logic [XLEN-1:0]      o_ra_data,

    input  wire reg_idx_t        i_rb_sel,
    output logic [XLEN-1:0]      o_rb_data,

    input  wire logic            i_w_en,
    input  wire reg_idx_t        i_w_sel,
    input  wire logic [XLEN-1:0] i_w_data
);

    logic [XLEN-1:0] regs [REG_COUNT];

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (i_w_en && i_w_sel != '0) begin
            regs[i_w_sel] <= i_w_data;
        end
    end

    // x0 reads as zero
    assign o_ra_data = (i_ra_sel == '0) ? '0 : regs[i_ra_sel];
    assign o_rb_data = (i_rb_sel == '0) ? '0 : regs[i_rb_sel];

endmodule

`default_nettype wire

//--- src/operand_bypass.sv
`timescale 1ns/1ns
`default_nettype none

module operand_bypass import exec_pkg::*; #(
    parameter int XLEN = 32
) (
    input  wire reg_idx_t        i_rs1,
    input  wire reg_idx_t        i_rs2,
    input  wire logic [XLEN-1:0] i_rf_rs1,
    input  wire logic [XLEN-1:0] i_rf_rs2,

    // EX1-to-EX2 register
    input  wire logic            i_ex_pending,
    input  wire reg_idx_t        i_ex_rd,
    input  wire logic            i_ex_value_valid,
    input  wire logic [XLEN-1:0] i_ex_data,

    // EX2 stage and its writeback
    input  wire logic            i_ex2_pending,
    input  wire reg_idx_t        i_ex2_rd,
    input  wire logic            i_wb_valid,
    input  wire logic [XLEN-1:0] i_wb_data,

    output logic [XLEN-1:0]      o_rs1,
    output logic [XLEN-1:0]      o_rs2,
    output logic                 o_stall
);

    logic [XLEN:0] res1;
    logic [XLEN:0] res2;

    // Top bit is the stall flag, the rest is the operand value
    function automatic logic [XLEN:0] pick(input reg_idx_t src, input logic [XLEN-1:0] rf_val);
        logic [XLEN:0] res;
        res = {1'b0, rf_val};
        // Younger producer first
        if (src != '0 && i_ex_pending && i_ex_rd == src) begin
            res = i_ex_value_valid ? {1'b0, i_ex_data} : {1'b1, rf_val};
        end else if (src != '0 && i_ex2_pending && i_ex2_rd == src) begin
            res = i_wb_valid ? {1'b0, i_wb_data} : {1'b1, rf_val};
        end
        return res;
    endfunction

    always_comb begin
        res1 = pick(i_rs1, i_rf_rs1);
        res2 = pick(i_rs2, i_rf_rs2);
    end

    assign o_rs1   = res1[XLEN-1:0];
    assign o_rs2   = res2[XLEN-1:0];
    assign o_stall = res1[XLEN] | res2[XLEN];

endmodule

`default_nettype wire

//--- src/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu import exec_pkg::*; #(
    parameter int XLEN = 32
) (
    input  wire op_e             i_op,
    input  wire logic [XLEN-1:0] i_a,
    input  wire logic [XLEN-1:0] i_b,
    output logic                 o_value_valid,
    output logic [XLEN-1:0]      o_val,
    output logic [XLEN-1:0]      o_val2
);

    logic [SHAMT_W-1:0] shamt;

    assign shamt = i_b[SHAMT_W-1:0];

    // Second operand always travels on, mul and div need it
    assign o_val2 = i_b;

    always_comb begin
        o_value_valid = 1'b1;
        o_val = i_a;
        unique case (i_op)
            OP_ADD: o_val = i_a + i_b;
            OP_SUB: o_val = i_a - i_b;
            OP_AND: o_val = i_a & i_b;
            OP_OR:  o_val = i_a | i_b;
            OP_XOR: o_val = i_a ^ i_b;
            OP_SLL: o_val = i_a << shamt;
            OP_SRL: o_val = i_a >> shamt;
            // Result comes later from EX2
            OP_MUL, OP_DIVU, OP_REMU: o_value_valid = 1'b0;
            default: o_value_valid = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- src/mul_unit.sv
`timescale 1ns/1ns
`default_nettype none

module mul_unit #(
    parameter int XLEN = 32
) (
    input  wire logic            clk,
    input  wire logic            resetn,
    input  wire logic            i_valid,
    input  wire logic [XLEN-1:0] i_a,
    input  wire logic [XLEN-1:0] i_b,
    output logic                 o_valid,
    output logic [XLEN-1:0]      o_value
);

    logic            v1_q;
    logic [XLEN-1:0] a_q;
    logic [XLEN-1:0] b_q;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            v1_q    <= 1'b0;
            o_valid <= 1'b0;
        end else begin
            v1_q    <= i_valid;
            o_valid <= v1_q;
        end
    end

    // Operand capture, then product truncated to XLEN
    always_ff @(posedge clk) begin
        if (i_valid) begin
            a_q <= i_a;
            b_q <= i_b;
        end
        if (v1_q) begin
            o_value <= a_q * b_q;
        end
    end

endmodule

`default_nettype wire

//--- src/div_unit.sv
`timescale 1ns/1ns
`default_nettype none

module div_unit #(
    parameter int XLEN = 32
) (
    input  wire logic            clk,
    input  wire logic            resetn,
    input  wire logic            i_valid,
    input  wire logic [XLEN-1:0] i_a,
    input  wire logic [XLEN-1:0] i_b,
    output logic                 o_valid,
    output logic [XLEN-1:0]      o_quo,
    output logic [XLEN-1:0]      o_rem
);

    localparam int CNT_W = $clog2(XLEN + 1);

    logic [CNT_W-1:0] cnt_q;
    logic [XLEN-1:0]  quo_q;
    logic [XLEN-1:0]  rem_q;
    logic [XLEN-1:0]  dvs_q;
    logic [XLEN:0]    trial;

    // Shifted partial remainder minus divisor, sign bit says restore
    assign trial = {rem_q, quo_q[XLEN-1]} - {1'b0, dvs_q};

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            cnt_q   <= '0;
            o_valid <= 1'b0;
        end else begin
            o_valid <= (cnt_q == CNT_W'(1));
            if (i_valid) begin
                cnt_q <= CNT_W'(XLEN);
            end else if (cnt_q != '0) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    // Dividend shifts out of quo_q while quotient bits shift in
    always_ff @(posedge clk) begin
        if (i_valid) begin
            quo_q <= i_a;
            rem_q <= '0;
            dvs_q <= i_b;
        end else if (cnt_q != '0) begin
            if (!trial[XLEN]) begin
                rem_q <= trial[XLEN-1:0];
            end else begin
                rem_q <= {rem_q[XLEN-2:0], quo_q[XLEN-1]};
            end
            quo_q <= {quo_q[XLEN-2:0], ~trial[XLEN]};
        end
    end

    assign o_quo = quo_q;
    assign o_rem = rem_q;

endmodule

`default_nettype wire

//--- src/ex2_stage.sv
`timescale 1ns/1ns
`default_nettype none

module ex2_stage import exec_pkg::*; #(
    parameter int XLEN = 32
) (
    input  wire logic            clk,
    input  wire logic            resetn,

    input  wire logic            i_valid,
    output logic                 o_ready,
    input  wire op_e             i_op,
    input  wire reg_idx_t        i_rd,
    input  wire logic [XLEN-1:0] i_data,
    input  wire logic [XLEN-1:0] i_data2,

    output logic                 o_pending,
    output reg_idx_t             o_rd,

    output logic                 o_wb_valid,
    output logic [XLEN-1:0]      o_wb_data
);

    typedef enum logic [1:0] {
        FU_ALU,
        FU_MUL,
        FU_DIV
    } func_unit_e;

    func_unit_e      sel_q;
    logic            use_rem_q;
    logic [XLEN-1:0] alu_data_q;
    logic            accept;
    logic            mul_valid;
    logic [XLEN-1:0] mul_value;
    logic            div_valid;
    logic [XLEN-1:0] div_quo;
    logic [XLEN-1:0] div_rem;

    // Idle, or finishing so a new op can follow back to back
    assign o_ready = !o_pending || o_wb_valid;
    assign accept  = i_valid && o_ready;

    mul_unit #(.XLEN(XLEN)) mul_i (
        .clk     (clk),
        .resetn  (resetn),
        .i_valid (accept && i_op == OP_MUL),
        .i_a     (i_data),
        .i_b     (i_data2),
        .o_valid (mul_valid),
        .o_value (mul_value)
    );

    div_unit #(.XLEN(XLEN)) div_i (
        .clk     (clk),
        .resetn  (resetn),
        .i_valid (accept && (i_op == OP_DIVU || i_op == OP_REMU)),
        .i_a     (i_data),
        .i_b     (i_data2),
        .o_valid (div_valid),
        .o_quo   (div_quo),
        .o_rem   (div_rem)
    );

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            o_pending <= 1'b0;
            o_rd      <= '0;
            sel_q     <= FU_ALU;
            use_rem_q <= 1'b0;
        end else if (accept) begin
            o_pending <= 1'b1;
            o_rd      <= i_rd;
            use_rem_q <= (i_op == OP_REMU);
            unique case (i_op)
                OP_MUL:           sel_q <= FU_MUL;
                OP_DIVU, OP_REMU: sel_q <= FU_DIV;
                default:          sel_q <= FU_ALU;
            endcase
        end else if (o_wb_valid) begin
            o_pending <= 1'b0;
        end
    end

    // ALU result was computed in EX1, held here for one cycle
    always_ff @(posedge clk) begin
        if (accept) begin
            alu_data_q <= i_data;
        end
    end

    always_comb begin
        o_wb_valid = 1'b0;
        o_wb_data  = alu_data_q;
        if (o_pending) begin
            unique case (sel_q)
                FU_ALU: o_wb_valid = 1'b1;
                FU_MUL: begin
                    o_wb_valid = mul_valid;
                    o_wb_data  = mul_value;
                end
                FU_DIV: begin
                    o_wb_valid = div_valid;
                    o_wb_data  = use_rem_q ? div_rem : div_quo;
                end
                default: o_wb_valid = 1'b0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/exec_core.sv
`timescale 1ns/1ns
`default_nettype none

module exec_core import exec_pkg::*; #(
    parameter int XLEN = 32
) (
    input  wire logic            clk,
    input  wire logic            resetn,

    input  wire logic            i_valid,
    output logic                 o_ready,
    input  wire op_e             i_op,
    input  wire reg_idx_t        i_rd,
    input  wire reg_idx_t        i_rs1,
    input  wire reg_idx_t        i_rs2,
    input  wire logic [XLEN-1:0] i_imm,
    input  wire logic            i_use_imm,

    output logic                 o_wb_valid,
    output reg_idx_t             o_wb_rd,
    output logic [XLEN-1:0]      o_wb_data
);

    // Issue register
    logic            iss_valid;
    op_e             iss_op;
    reg_idx_t        iss_rd;
    reg_idx_t        iss_rs1;
    reg_idx_t        iss_rs2;
    logic [XLEN-1:0] iss_imm;
    logic            iss_use_imm;

    logic [XLEN-1:0] rf_rs1;
    logic [XLEN-1:0] rf_rs2;
    logic [XLEN-1:0] byp_rs1;
    logic [XLEN-1:0] byp_rs2;
    reg_idx_t        rs2_src;
    logic            stall;

    logic            alu_value_valid;
    logic [XLEN-1:0] alu_val;
    logic [XLEN-1:0] alu_val2;

    // EX1-to-EX2 register
    logic            ex_pending;
    op_e             ex_op;
    reg_idx_t        ex_rd;
    logic            ex_value_valid;
    logic [XLEN-1:0] ex_data;
    logic [XLEN-1:0] ex_data2;

    logic            ex2_ready;
    logic            ex2_pending;
    logic            ex_go;
    logic            issue_go;

    assign ex_go    = ex_pending && ex2_ready;
    assign issue_go = iss_valid && (!ex_pending || ex_go) && !stall;
    assign o_ready  = !iss_valid || ((!ex_pending || ex_go) && !stall);

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            iss_valid <= 1'b0;
        end else if (i_valid && o_ready) begin
            iss_valid <= 1'b1;
        end else if (issue_go) begin
            iss_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (i_valid && o_ready) begin
            iss_op      <= i_op;
            iss_rd      <= i_rd;
            iss_rs1     <= i_rs1;
            iss_rs2     <= i_rs2;
            iss_imm     <= i_imm;
            iss_use_imm <= i_use_imm;
        end
    end

    reg_file #(.XLEN(XLEN)) reg_file_i (
        .clk       (clk),
        .resetn    (resetn),
        .i_ra_sel  (iss_rs1),
        .o_ra_data (rf_rs1),
        .i_rb_sel  (iss_rs2),
        .o_rb_data (rf_rs2),
        .i_w_en    (o_wb_valid),
        .i_w_sel   (o_wb_rd),
        .i_w_data  (o_wb_data)
    );

    // An immediate op has no second source to wait for
    assign rs2_src = iss_use_imm ? reg_idx_t'(0) : iss_rs2;

    operand_bypass #(.XLEN(XLEN)) operand_bypass_i (
        .i_rs1            (iss_rs1),
        .i_rs2            (rs2_src),
        .i_rf_rs1         (rf_rs1),
        .i_rf_rs2         (rf_rs2),
        .i_ex_pending     (ex_pending),
        .i_ex_rd          (ex_rd),
        .i_ex_value_valid (ex_value_valid),
        .i_ex_data        (ex_data),
        .i_ex2_pending    (ex2_pending),
        .i_ex2_rd         (o_wb_rd),
        .i_wb_valid       (o_wb_valid),
        .i_wb_data        (o_wb_data),
        .o_rs1            (byp_rs1),
        .o_rs2            (byp_rs2),
        .o_stall          (stall)
    );

    alu #(.XLEN(XLEN)) alu_i (
        .i_op          (iss_op),
        .i_a           (byp_rs1),
        .i_b           (iss_use_imm ? iss_imm : byp_rs2),
        .o_value_valid (alu_value_valid),
        .o_val         (alu_val),
        .o_val2        (alu_val2)
    );

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            ex_pending     <= 1'b0;
            ex_value_valid <= 1'b0;
        end else if (issue_go) begin
            ex_pending     <= 1'b1;
            ex_value_valid <= alu_value_valid;
        end else if (ex_go) begin
            ex_pending     <= 1'b0;
            ex_value_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_go) begin
            ex_op    <= iss_op;
            ex_rd    <= iss_rd;
            ex_data  <= alu_val;
            ex_data2 <= alu_val2;
        end
    end

    ex2_stage #(.XLEN(XLEN)) ex2_stage_i (
        .clk        (clk),
        .resetn     (resetn),
        .i_valid    (ex_pending),
        .o_ready    (ex2_ready),
        .i_op       (ex_op),
        .i_rd       (ex_rd),
        .i_data     (ex_data),
        .i_data2    (ex_data2),
        .o_pending  (ex2_pending),
        .o_rd       (o_wb_rd),
        .o_wb_valid (o_wb_valid),
        .o_wb_data  (o_wb_data)
    );

endmodule

`default_nettype wire

//--- dv/tb_exec_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_exec_core import exec_pkg::*; ();

    localparam int XLEN       = 32;
    localparam int CLK_PERIOD = 100;

    localparam int N_LOAD  = REG_COUNT - 1;
    localparam int N_RAND  = 200;
    localparam int N_CHAIN = 60;
    localparam int N_MUL   = 40;
    localparam int N_DIV   = 40;
    localparam int N_DIVZ  = 4;
    localparam int N_WAIT  = 20;
    localparam int N_X0    = 12;
    localparam int TOTAL_INSTR = N_LOAD + N_RAND + N_CHAIN + N_MUL + N_DIV
                               + 4 * N_DIVZ + 3 * N_WAIT + 3 * N_X0;
    // Enough for every instruction to be a divide
    localparam int CYCLE_LIMIT = TOTAL_INSTR * (XLEN + 8) + 200;

    logic            clk;
    logic            resetn;
    logic            i_valid;
    logic            o_ready;
    op_e             i_op;
    reg_idx_t        i_rd;
    reg_idx_t        i_rs1;
    reg_idx_t        i_rs2;
    logic [XLEN-1:0] i_imm;
    logic            i_use_imm;
    logic            o_wb_valid;
    reg_idx_t        o_wb_rd;
    logic [XLEN-1:0] o_wb_data;

    logic [XLEN-1:0] model_regs [REG_COUNT];
    reg_idx_t        exp_rd_q [$];
    logic [XLEN-1:0] exp_data_q [$];
    logic [31:0]     rng_state = 32'd82;
    int              cycle_count;
    logic            watch_ready;
    logic            ready_low_seen;

    exec_core #(.XLEN(XLEN)) dut_i (
        .clk        (clk),
        .resetn     (resetn),
        .i_valid    (i_valid),
        .o_ready    (o_ready),
        .i_op       (i_op),
        .i_rd       (i_rd),
        .i_rs1      (i_rs1),
        .i_rs2      (i_rs2),
        .i_imm      (i_imm),
        .i_use_imm  (i_use_imm),
        .o_wb_valid (o_wb_valid),
        .o_wb_rd    (o_wb_rd),
        .o_wb_data  (o_wb_data)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [XLEN-1:0] expected,
                               input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            stop_with_error($sformatf("[FAIL] t=%0t %s expected 0x%h actual 0x%h",
                                      $time, name, expected, actual));
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] rand_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic reg_idx_t rand_reg();
        logic [31:0] w;
        w = rand_word();
        return w[4:0];
    endfunction

    function automatic reg_idx_t rand_nz_reg();
        return reg_idx_t'(1 + rand_word() % (REG_COUNT - 1));
    endfunction

    // Ops 0 to 6 are the single-cycle ALU ops
    function automatic op_e rand_alu_op();
        return op_e'(rand_word() % 7);
    endfunction

    // Returns {rd, data} and updates the model registers
    function automatic logic [XLEN+4:0] exec_model(input op_e op, input reg_idx_t rd,
                                                   input reg_idx_t rs1, input reg_idx_t rs2,
                                                   input logic [XLEN-1:0] imm,
                                                   input logic use_imm);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] res;
        a = model_regs[rs1];
        b = use_imm ? imm : model_regs[rs2];
        case (op)
            OP_ADD:  res = a + b;
            OP_SUB:  res = a - b;
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            OP_XOR:  res = a ^ b;
            OP_SLL:  res = a << b[SHAMT_W-1:0];
            OP_SRL:  res = a >> b[SHAMT_W-1:0];
            OP_MUL:  res = a * b;
            OP_DIVU: res = (b == '0) ? '1 : a / b;
            OP_REMU: res = (b == '0) ? a : a % b;
            default: res = 'x;
        endcase
        if (rd != '0) begin
            model_regs[rd] = res;
        end
        return {rd, res};
    endfunction

    task automatic send_instr(input op_e op, input reg_idx_t rd, input reg_idx_t rs1,
                              input reg_idx_t rs2, input logic [XLEN-1:0] imm,
                              input logic use_imm);
        logic [XLEN+4:0] expect_wb;
        @(negedge clk);
        i_valid   = 1'b1;
        i_op      = op;
        i_rd      = rd;
        i_rs1     = rs1;
        i_rs2     = rs2;
        i_imm     = imm;
        i_use_imm = use_imm;
        while (!o_ready) begin
            if (watch_ready) begin
                ready_low_seen = 1'b1;
            end
            @(negedge clk);
        end
        // Taken at the coming rising edge
        expect_wb = exec_model(op, rd, rs1, rs2, imm, use_imm);
        exp_rd_q.push_back(expect_wb[XLEN+4:XLEN]);
        exp_data_q.push_back(expect_wb[XLEN-1:0]);
    endtask

    // Queue only changes on falling edges, so it is polled on rising ones
    task automatic drain_pipeline();
        @(negedge clk);
        i_valid = 1'b0;
        while (exp_rd_q.size() != 0) begin
            @(posedge clk);
        end
    endtask

    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count >= CYCLE_LIMIT) begin
                stop_with_error("Timeout: the writebacks did not finish in time");
            end
        end
    end

    // Writeback checker in program order
    initial begin
        reg_idx_t        exp_rd;
        logic [XLEN-1:0] exp_data;
        forever begin
            @(negedge clk);
            if (resetn === 1'b1 && o_wb_valid === 1'b1) begin
                if (exp_rd_q.size() == 0) begin
                    stop_with_error("A writeback came with no instruction outstanding");
                end else begin
                    exp_rd   = exp_rd_q.pop_front();
                    exp_data = exp_data_q.pop_front();
                    check_value("o_wb_rd", XLEN'(exp_rd), XLEN'(o_wb_rd));
                    check_value("o_wb_data", exp_data, o_wb_data);
                end
            end
        end
    end

    initial begin
        reg_idx_t        rd;
        reg_idx_t        rs1;
        reg_idx_t        rs2;
        reg_idx_t        prev;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] w;
        resetn         = 1'b0;
        i_valid        = 1'b0;
        i_op           = OP_ADD;
        i_rd           = '0;
        i_rs1          = '0;
        i_rs2          = '0;
        i_imm          = '0;
        i_use_imm      = 1'b0;
        watch_ready    = 1'b0;
        ready_low_seen = 1'b0;
        for (int r = 0; r < REG_COUNT; r++) begin
            model_regs[r] = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;

        // Fill registers from x0
        for (int r = 1; r < REG_COUNT; r++) begin
            rs2 = rand_reg();
            send_instr(OP_ADD, reg_idx_t'(r), '0, rs2, rand_word(), 1'b1);
        end
        for (int i = 0; i < N_RAND; i++) begin
            rd  = rand_reg();
            rs1 = rand_reg();
            rs2 = rand_reg();
            imm = rand_word();
            send_instr(rand_alu_op(), rd, rs1, rs2, imm, imm[7]);
        end

        // Dependent chains on rs1, rs2 and both
        prev = rand_nz_reg();
        for (int i = 0; i < N_CHAIN; i++) begin
            rd  = rand_nz_reg();
            rs1 = (i % 3 != 1) ? prev : rand_reg();
            rs2 = (i % 3 != 0) ? prev : rand_reg();
            send_instr(rand_alu_op(), rd, rs1, rs2, '0, 1'b0);
            prev = rd;
        end

        for (int i = 0; i < N_MUL; i++) begin
            rd  = rand_reg();
            rs1 = rand_reg();
            rs2 = rand_reg();
            imm = rand_word();
            send_instr(OP_MUL, rd, rs1, rs2, imm, imm[3:0] == 4'h0);
        end

        // Divisor sizes vary through the shift
        for (int i = 0; i < N_DIV; i++) begin
            rd  = rand_reg();
            rs1 = rand_reg();
            rs2 = rand_reg();
            w   = rand_word();
            send_instr((i % 2 == 0) ? OP_DIVU : OP_REMU, rd, rs1, rs2, w >> w[4:0], w[5]);
        end

        // Divide by zero from x0 and from the immediate
        for (int i = 0; i < N_DIVZ; i++) begin
            rs1 = rand_nz_reg();
            rs2 = rand_reg();
            send_instr(OP_DIVU, rand_nz_reg(), rs1, '0, '0, 1'b0);
            send_instr(OP_REMU, rand_nz_reg(), rs1, '0, '0, 1'b0);
            send_instr(OP_DIVU, rand_nz_reg(), rs1, rs2, '0, 1'b1);
            send_instr(OP_REMU, rand_nz_reg(), rs1, rs2, '0, 1'b1);
        end

        // ALU ops right behind a mul or divu result
        for (int i = 0; i < N_WAIT; i++) begin
            // Empty pipeline, so the add stalls in its first issue cycle
            drain_pipeline();
            prev = rand_nz_reg();
            rd   = rand_nz_reg();
            rs1  = rand_reg();
            rs2  = rand_reg();
            send_instr((i % 2 == 0) ? OP_MUL : OP_DIVU, prev, rs1, rs2, rand_word(), i % 4 >= 2);
            rs2 = rand_reg();
            send_instr(OP_ADD, rd, prev, rs2, '0, 1'b0);
            watch_ready = 1'b1;
            send_instr(OP_XOR, rand_nz_reg(), rd, prev, '0, 1'b0);
            watch_ready = 1'b0;
        end

        // Writes to x0 never show up in later reads
        for (int i = 0; i < N_X0; i++) begin
            rd  = rand_nz_reg();
            rs1 = rand_nz_reg();
            rs2 = rand_reg();
            send_instr((i % 2 == 0) ? OP_ADD : OP_MUL, '0, rs1, rs2, rand_word(), 1'b1);
            rs2 = rand_nz_reg();
            send_instr(OP_SUB, rd, '0, rs2, '0, 1'b0);
            send_instr(OP_OR, rand_nz_reg(), rd, '0, '0, 1'b0);
        end

        drain_pipeline();
        repeat (4) @(negedge clk);
        if (!ready_low_seen) begin
            stop_with_error("o_ready never went low while an op waited on a mul or divu result");
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- build.f
src/exec_pkg.sv
src/reg_file.sv
src/operand_bypass.sv
src/alu.sv
src/mul_unit.sv
src/div_unit.sv
src/ex2_stage.sv
src/exec_core.sv
dv/tb_exec_core.sv

//--- Bender.yml
package:
  name: exec_core

sources:
  - src/exec_pkg.sv
  - src/reg_file.sv
  - src/operand_bypass.sv
  - src/alu.sv
  - src/mul_unit.sv
  - src/div_unit.sv
  - src/ex2_stage.sv
  - src/exec_core.sv
  - target: test
    files:
      - dv/tb_exec_core.sv
